//--- flist.f
source/jacobian_pkg.sv
source/jacobian_sequencer.sv
source/lane_multiplier.sv
source/jacobian_columns.sv
source/jjt_bias.sv
source/jacobian_top.sv
tb/jacobian_chk.sv
tb/tb_jacobian.sv

//--- tb/tb_jacobian.sv
/*
 * testbench for the damped Jacobian engine
 * loads random and extreme arms, runs the engine back to back and checks
 * every column and J*J' entry against a longint reference model
 */
`timescale 1ns/1ps

module tb_jacobian import jacobian_pkg::*; ();

	localparam int N = 3;
	localparam int RUNS = 20;
	localparam int RUN_CYCLES = N + 41;
	localparam int LIMIT = RUNS * 60 + 200;
	localparam longint CMAX = (longint'(1) <<< (COORD_W - 1)) - 1;
	localparam longint CMIN = -CMAX - 1;

	logic                      i;
	logic                      rst_n;
	logic                      joint_load;
	logic [IDX_W-1:0]          joint_index;
	logic                      joint_prismatic;
	logic signed [COORD_W-1:0] axis_x;
	logic signed [COORD_W-1:0] axis_y;
	logic signed [COORD_W-1:0] axis_z;
	logic signed [COORD_W-1:0] origin_x;
	logic signed [COORD_W-1:0] origin_y;
	logic signed [COORD_W-1:0] origin_z;
	logic                      start;
	logic signed [COORD_W-1:0] end_x;
	logic signed [COORD_W-1:0] end_y;
	logic signed [COORD_W-1:0] end_z;
	logic                      busy;
	logic                      done;
	logic                      jac_valid;
	logic [IDX_W-1:0]          jac_joint;
	logic [5:0][JAC_W-1:0]     jac_column;
	logic                      jjt_valid;
	logic [IDX_W-1:0]          jjt_row;
	logic [IDX_W-1:0]          jjt_col;
	logic signed [JJT_W-1:0]   jjt_entry;

	// model of the arm as the engine should see it
	longint model_axis   [MAX_JOINTS][3];
	longint model_origin [MAX_JOINTS][3];
	bit     model_prism  [MAX_JOINTS];
	longint model_end    [3];
	longint exp_jac      [6][MAX_JOINTS];
	longint exp_jjt      [6][6];
	longint got_jjt      [6][6];

	int cyc = 0;
	int start_edge = 0;
	int jac_seen = 0;
	int jjt_seen = 0;
	int runs_done = 0;
	int checks = 0;
	int err_value = 0;
	int err_other = 0;

	jacobian_top #(
		.N_JOINTS(N)
	) i_jacobian_top (
		.i(i), .rst_n(rst_n),
		.joint_load(joint_load), .joint_index(joint_index), .joint_prismatic(joint_prismatic),
		.axis_x(axis_x), .axis_y(axis_y), .axis_z(axis_z),
		.origin_x(origin_x), .origin_y(origin_y), .origin_z(origin_z),
		.start(start), .end_x(end_x), .end_y(end_y), .end_z(end_z),
		.busy(busy), .done(done),
		.jac_valid(jac_valid), .jac_joint(jac_joint), .jac_column(jac_column),
		.jjt_valid(jjt_valid), .jjt_row(jjt_row), .jjt_col(jjt_col), .jjt_entry(jjt_entry)
	);

	always #5 i = ~i;

	always @(posedge i) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("timeout after %0d cycles, %0d of %0d runs finished", cyc, runs_done, RUNS);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// revolute joint gives axis x (end - origin) over the axis
	// prismatic joint gives the axis over zero
	function automatic void compute_reference();
		longint a [3];
		longint d [3];
		longint sum;
		for (int j = 0; j < N; j++) begin
			for (int c = 0; c < 3; c++) begin
				a[c] = model_axis[j][c];
				d[c] = model_end[c] - model_origin[j][c];
			end
			if (model_prism[j]) begin
				for (int c = 0; c < 3; c++) begin
					exp_jac[c][j] = a[c];
					exp_jac[c+3][j] = 0;
				end
			end else begin
				exp_jac[0][j] = a[1] * d[2] - a[2] * d[1];
				exp_jac[1][j] = a[2] * d[0] - a[0] * d[2];
				exp_jac[2][j] = a[0] * d[1] - a[1] * d[0];
				for (int c = 0; c < 3; c++) begin
					exp_jac[c+3][j] = a[c];
				end
			end
		end
		for (int r = 0; r < 6; r++) begin
			for (int c = 0; c < 6; c++) begin
				sum = (r == c) ? longint'(DAMP_BIAS) : 0;
				for (int j = 0; j < N; j++) begin
					sum += exp_jac[r][j] * exp_jac[c][j];
				end
				exp_jjt[r][c] = sum;
			end
		end
	endfunction

	function automatic longint rand_coord(input bit extreme);
		logic signed [COORD_W-1:0] v;
		v = COORD_W'($urandom);
		if (extreme) begin
			v = v[0] ? COORD_W'(CMAX) : COORD_W'(CMIN);
		end
		return longint'(v);
	endfunction

	task automatic load_values(input int idx, input bit prism, input longint ax, input longint ay,
		input longint az, input longint ox, input longint oy, input longint oz);
		@(posedge i);
		#1;
		joint_load = 1'b1;
		joint_index = IDX_W'(idx);
		joint_prismatic = prism;
		axis_x = COORD_W'(ax);
		axis_y = COORD_W'(ay);
		axis_z = COORD_W'(az);
		origin_x = COORD_W'(ox);
		origin_y = COORD_W'(oy);
		origin_z = COORD_W'(oz);
		model_prism[idx] = prism;
		model_axis[idx][0] = ax;
		model_axis[idx][1] = ay;
		model_axis[idx][2] = az;
		model_origin[idx][0] = ox;
		model_origin[idx][1] = oy;
		model_origin[idx][2] = oz;
		@(posedge i);
		#1;
		joint_load = 1'b0;
	endtask

	task automatic load_random(input int idx, input bit prism, input bit extreme);
		longint v [6];
		for (int k = 0; k < 6; k++) begin
			v[k] = rand_coord(extreme);
		end
		load_values(idx, prism, v[0], v[1], v[2], v[3], v[4], v[5]);
	endtask

	// strobes that must be dropped and leave the model alone
	task automatic poke_busy(input bit with_start);
		if (!busy) begin
			err_other++;
			$display("ERROR at %0t: engine idle when ignored strobes were due", $time);
		end
		@(posedge i);
		#1;
		joint_load = 1'b1;
		joint_index = IDX_W'($urandom_range(N - 1, 0));
		joint_prismatic = 1'($urandom);
		axis_x = COORD_W'($urandom);
		axis_y = COORD_W'($urandom);
		axis_z = COORD_W'($urandom);
		origin_x = COORD_W'($urandom);
		origin_y = COORD_W'($urandom);
		origin_z = COORD_W'($urandom);
		if (with_start) begin
			start = 1'b1;
			end_x = COORD_W'($urandom);
			end_y = COORD_W'($urandom);
			end_z = COORD_W'($urandom);
		end
		@(posedge i);
		#1;
		joint_load = 1'b0;
		start = 1'b0;
	endtask

	task automatic start_run(input longint ex, input longint ey, input longint ez, input bit poke);
		@(negedge i);
		while (busy) @(negedge i);
		model_end[0] = ex;
		model_end[1] = ey;
		model_end[2] = ez;
		compute_reference();
		@(posedge i);
		#1;
		start = 1'b1;
		end_x = COORD_W'(ex);
		end_y = COORD_W'(ey);
		end_z = COORD_W'(ez);
		start_edge = cyc + 1;
		@(posedge i);
		#1;
		start = 1'b0;
		if (poke) begin
			// first poke lands before the last offset is taken
			repeat (2) @(negedge i);
			poke_busy(1'b1);
			repeat (14) @(negedge i);
			poke_busy(1'b0);
			repeat (14) @(negedge i);
			poke_busy(1'b1);
		end
		do @(negedge i); while (!done);
	endtask

	task automatic close_run();
		if (!(jjt_valid && jjt_row == IDX_W'(5) && jjt_col == IDX_W'(5))) begin
			err_other++;
			$display("ERROR at %0t: done did not come with entry (5,5)", $time);
		end
		checks++;
		if (cyc - start_edge != RUN_CYCLES) begin
			err_value++;
			$display("CHECK FAILED t=%0t done latency expected %0d got %0d",
				$time, RUN_CYCLES, cyc - start_edge);
		end
		if (jac_seen != N || jjt_seen != 36) begin
			err_other++;
			$display("ERROR at %0t: run gave %0d columns and %0d entries", $time, jac_seen, jjt_seen);
		end
		// mirrored entry against the reference of its partner
		for (int r = 0; r < 6; r++) begin
			for (int c = r + 1; c < 6; c++) begin
				if (got_jjt[c][r] != exp_jjt[r][c]) begin
					err_value++;
					$display("CHECK FAILED t=%0t jjt_entry(%0d,%0d) expected %0d got %0d",
						$time, c, r, exp_jjt[r][c], got_jjt[c][r]);
				end
			end
		end
		jac_seen = 0;
		jjt_seen = 0;
		runs_done++;
	endtask

	// outputs sampled mid-cycle
	always @(negedge i) begin
		int r;
		int c;
		if (rst_n) begin
			if (jac_valid) begin
				checks++;
				if (jac_joint != IDX_W'(jac_seen)) begin
					err_value++;
					$display("CHECK FAILED t=%0t jac_joint expected %0d got %0d",
						$time, jac_seen, jac_joint);
				end
				if (jac_seen < N) begin
					for (int k = 0; k < 6; k++) begin
						if (longint'($signed(jac_column[k])) != exp_jac[k][jac_seen]) begin
							err_value++;
							$display("CHECK FAILED t=%0t jac_column[%0d] joint %0d expected %0d got %0d",
								$time, k, jac_seen, exp_jac[k][jac_seen], $signed(jac_column[k]));
						end
					end
				end else begin
					err_other++;
					$display("ERROR at %0t: more columns than joints", $time);
				end
				jac_seen++;
			end
			if (jjt_valid) begin
				checks++;
				if (jjt_seen < 36) begin
					r = jjt_seen / 6;
					c = jjt_seen % 6;
					if (jjt_row != IDX_W'(r) || jjt_col != IDX_W'(c)) begin
						err_value++;
						$display("CHECK FAILED t=%0t jjt_row/jjt_col expected (%0d,%0d) got (%0d,%0d)",
							$time, r, c, jjt_row, jjt_col);
					end
					if (longint'(jjt_entry) != exp_jjt[r][c]) begin
						err_value++;
						$display("CHECK FAILED t=%0t jjt_entry(%0d,%0d) expected %0d got %0d",
							$time, r, c, exp_jjt[r][c], jjt_entry);
					end
					got_jjt[r][c] = longint'(jjt_entry);
				end else begin
					err_other++;
					$display("ERROR at %0t: more than 36 product entries", $time);
				end
				jjt_seen++;
			end
			if (done) begin
				close_run();
			end
		end
	end

	initial begin
		int seed;
		seed = 32'h29b0_9fcc;
		void'($urandom(seed));
		i = 1'b0;
		rst_n = 1'b0;
		joint_load = 1'b0;
		joint_index = '0;
		joint_prismatic = 1'b0;
		axis_x = '0;
		axis_y = '0;
		axis_z = '0;
		origin_x = '0;
		origin_y = '0;
		origin_z = '0;
		start = 1'b0;
		end_x = '0;
		end_y = '0;
		end_z = '0;
		repeat (2) @(posedge i);
		#1;
		rst_n = 1'b1;

		// revolute arms
		for (int r = 0; r < 4; r++) begin
			for (int j = 0; j < N; j++) load_random(j, 1'b0, 1'b0);
			start_run(rand_coord(1'b0), rand_coord(1'b0), rand_coord(1'b0), 1'b0);
		end
		// mixed arms with the last one all prismatic
		for (int r = 4; r < 8; r++) begin
			for (int j = 0; j < N; j++) load_random(j, (r == 7) ? 1'b1 : 1'($urandom), 1'b0);
			start_run(rand_coord(1'b0), rand_coord(1'b0), rand_coord(1'b0), 1'b0);
		end
		// full-scale offsets and then random corners of the coordinate range
		load_values(0, 1'b0, CMAX, CMIN, CMAX, CMIN, CMIN, CMIN);
		load_values(1, 1'b0, CMIN, CMAX, CMIN, CMIN, CMAX, CMIN);
		load_values(2, 1'b1, CMIN, CMIN, CMIN, CMAX, CMAX, CMAX);
		start_run(CMAX, CMAX, CMAX, 1'b0);
		for (int r = 9; r < 11; r++) begin
			for (int j = 0; j < N; j++) load_random(j, 1'($urandom), 1'b1);
			start_run(rand_coord(1'b1), rand_coord(1'b1), rand_coord(1'b1), 1'b0);
		end
		// strobes while busy against the table loaded here
		for (int j = 0; j < N; j++) load_random(j, 1'($urandom), 1'b0);
		for (int r = 11; r < 14; r++) begin
			start_run(rand_coord(1'b0), rand_coord(1'b0), rand_coord(1'b0), 1'b1);
		end
		// back to back with only a new end point
		for (int r = 14; r < RUNS; r++) begin
			start_run(rand_coord(1'b0), rand_coord(1'b0), rand_coord(1'b0), 1'b0);
		end
		repeat (3) @(posedge i);

		if (runs_done != RUNS) begin
			err_other++;
			$display("ERROR: %0d of %0d runs finished", runs_done, RUNS);
		end
		$display("checks %0d, value mismatches %0d, other errors %0d", checks, err_value, err_other);
		if (err_value == 0 && err_other == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- tb/jacobian_chk.sv
/*
 * jacobian checker
 * concurrent assertions on strobes, lane sharing and done, bound into
 * the top level
 */
`timescale 1ns/1ps

module jacobian_chk import jacobian_pkg::*; (
	input logic                        i,
	input logic                        rst_n,
	input logic                        busy,
	input logic                        done,
	input logic                        jac_valid,
	input logic                        jjt_valid,
	input logic [IDX_W-1:0]            jjt_row,
	input logic [IDX_W-1:0]            jjt_col,
	input logic [LANES-1:0][JAC_W-1:0] col_lane_a,
	input logic [LANES-1:0][JAC_W-1:0] jjt_lane_a
);

	// column and entry beats never overlap
	valid_excl: assert property (@(posedge i) disable iff (!rst_n) !(jac_valid && jjt_valid))
		else $error("jac_valid and jjt_valid high in the same cycle");

	// only one user of the shared lanes at a time
	lane_excl: assert property (@(posedge i) disable iff (!rst_n) !((|col_lane_a) && (|jjt_lane_a)))
		else $error("column and product operands on the lanes together");

	done_last: assert property (@(posedge i) disable iff (!rst_n)
		done |-> (jjt_valid && jjt_row == IDX_W'(5) && jjt_col == IDX_W'(5)))
		else $error("done without the last product entry");

	busy_reset: assert property (@(posedge i) !rst_n |=> !busy)
		else $error("busy high after reset");

endmodule

bind jacobian_top jacobian_chk i_jacobian_chk (
	.i(i), .rst_n(rst_n), .busy(busy), .done(done),
	.jac_valid(jac_valid), .jjt_valid(jjt_valid), .jjt_row(jjt_row), .jjt_col(jjt_col),
	.col_lane_a(col_lane_a), .jjt_lane_a(jjt_lane_a)
);

//--- source/jacobian_top.sv
/*
 * jacobian top
 * damped Jacobian engine: sequencer, column pipe and J*J' stage
 * around one shared bank of multiplier lanes
 */
`timescale 1ns/1ps

module jacobian_top import jacobian_pkg::*; #(
	parameter int N_JOINTS = 3
) (
	input  logic                      i,
	input  logic                      rst_n,
	input  logic                      joint_load,
	input  logic [IDX_W-1:0]          joint_index,
	input  logic                      joint_prismatic,
	input  logic signed [COORD_W-1:0] axis_x,
	input  logic signed [COORD_W-1:0] axis_y,
	input  logic signed [COORD_W-1:0] axis_z,
	input  logic signed [COORD_W-1:0] origin_x,
	input  logic signed [COORD_W-1:0] origin_y,
	input  logic signed [COORD_W-1:0] origin_z,
	input  logic                      start,
	input  logic signed [COORD_W-1:0] end_x,
	input  logic signed [COORD_W-1:0] end_y,
	input  logic signed [COORD_W-1:0] end_z,
	output logic                      busy,
	output logic                      done,
	output logic                      jac_valid,
	output logic [IDX_W-1:0]          jac_joint,
	output logic [5:0][JAC_W-1:0]     jac_column,
	output logic                      jjt_valid,
	output logic [IDX_W-1:0]          jjt_row,
	output logic [IDX_W-1:0]          jjt_col,
	output logic signed [JJT_W-1:0]   jjt_entry
);

	logic                         col_issue;
	logic [IDX_W-1:0]             col_joint;
	logic                         ent_issue;
	logic [IDX_W-1:0]             ent_row;
	logic [IDX_W-1:0]             ent_col;
	logic                         load_ok;
	logic                         start_ok;
	logic [LANES-1:0][JAC_W-1:0]  col_lane_a;
	logic [LANES-1:0][JAC_W-1:0]  col_lane_b;
	logic [LANES-1:0][JAC_W-1:0]  jjt_lane_a;
	logic [LANES-1:0][JAC_W-1:0]  jjt_lane_b;
	logic [LANES-1:0][JAC_W-1:0]  lane_a;
	logic [LANES-1:0][JAC_W-1:0]  lane_b;
	logic [LANES-1:0][PROD_W-1:0] lane_prod;

	// table and end point are frozen while a run is active
	assign load_ok  = joint_load & ~busy;
	assign start_ok = start & ~busy;

	// phase order keeps the two users apart, idle side drives zeros
	assign lane_a = col_lane_a | jjt_lane_a;
	assign lane_b = col_lane_b | jjt_lane_b;

	jacobian_sequencer #(
		.N_JOINTS(N_JOINTS)
	) i_jacobian_sequencer (
		.i(i), .rst_n(rst_n), .start(start),
		.busy(busy), .done(done),
		.col_issue(col_issue), .col_joint(col_joint),
		.ent_issue(ent_issue), .ent_row(ent_row), .ent_col(ent_col)
	);

	lane_multiplier i_lane_multiplier (
		.i(i), .lane_a(lane_a), .lane_b(lane_b), .lane_prod(lane_prod)
	);

	jacobian_columns #(
		.N_JOINTS(N_JOINTS)
	) i_jacobian_columns (
		.i(i), .rst_n(rst_n),
		.joint_load(load_ok), .joint_index(joint_index), .joint_prismatic(joint_prismatic),
		.axis_x(axis_x), .axis_y(axis_y), .axis_z(axis_z),
		.origin_x(origin_x), .origin_y(origin_y), .origin_z(origin_z),
		.start(start_ok), .end_x(end_x), .end_y(end_y), .end_z(end_z),
		.col_issue(col_issue), .col_joint(col_joint), .lane_prod(lane_prod),
		.col_lane_a(col_lane_a), .col_lane_b(col_lane_b),
		.jac_valid(jac_valid), .jac_joint(jac_joint), .jac_column(jac_column)
	);

	jjt_bias #(
		.N_JOINTS(N_JOINTS)
	) i_jjt_bias (
		.i(i), .rst_n(rst_n),
		.jac_valid(jac_valid), .jac_joint(jac_joint), .jac_column(jac_column),
		.ent_issue(ent_issue), .ent_row(ent_row), .ent_col(ent_col),
		.lane_prod(lane_prod),
		.jjt_lane_a(jjt_lane_a), .jjt_lane_b(jjt_lane_b),
		.jjt_valid(jjt_valid), .jjt_row(jjt_row), .jjt_col(jjt_col),
		.jjt_entry(jjt_entry)
	);

endmodule

//--- source/jjt_bias.sv
/*
 * jjt bias
 * stores the Jacobian columns and forms each entry of J*J' + bias*I
 * as a dot product over the shared lanes, one entry per cycle
 */
`timescale 1ns/1ps

module jjt_bias import jacobian_pkg::*; #(
	parameter int N_JOINTS = 3
) (
	input  logic                         i,
	input  logic                         rst_n,
	input  logic                         jac_valid,
	input  logic [IDX_W-1:0]             jac_joint,
	input  logic [5:0][JAC_W-1:0]        jac_column,
	input  logic                         ent_issue,
	input  logic [IDX_W-1:0]             ent_row,
	input  logic [IDX_W-1:0]             ent_col,
	input  logic [LANES-1:0][PROD_W-1:0] lane_prod,
	output logic [LANES-1:0][JAC_W-1:0]  jjt_lane_a,
	output logic [LANES-1:0][JAC_W-1:0]  jjt_lane_b,
	output logic                         jjt_valid,
	output logic [IDX_W-1:0]             jjt_row,
	output logic [IDX_W-1:0]             jjt_col,
	output logic signed [JJT_W-1:0]      jjt_entry
);

	// one stored column per joint
	logic [5:0][JAC_W-1:0]   col_store [MAX_JOINTS];

	logic                    s1_valid;
	logic [IDX_W-1:0]        row_q;
	logic [IDX_W-1:0]        col_q;
	logic signed [JJT_W-1:0] prod_sum;
	logic signed [JJT_W-1:0] bias;

	always_ff @(posedge i) begin
		if (jac_valid) begin
			col_store[jac_joint] <= jac_column;
		end
	end

	// lane j carries J[row][j] and J[col][j]
	always_comb begin
		jjt_lane_a = '0;
		jjt_lane_b = '0;
		if (ent_issue) begin
			for (int j = 0; j < LANES; j++) begin
				if (j < N_JOINTS) begin
					jjt_lane_a[j] = col_store[j][ent_row];
					jjt_lane_b[j] = col_store[j][ent_col];
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			jjt_valid <= 1'b0;
		end else begin
			s1_valid  <= ent_issue;
			jjt_valid <= s1_valid;
		end
	end

	// indices follow the entry while the lanes multiply
	always_ff @(posedge i) begin
		if (ent_issue) begin
			row_q <= ent_row;
			col_q <= ent_col;
		end
	end

	// unused lanes return zero
	always_comb begin
		prod_sum = '0;
		for (int j = 0; j < LANES; j++) begin
			prod_sum = prod_sum + JJT_W'($signed(lane_prod[j]));
		end
	end

	// damping on the diagonal only
	assign bias = (row_q == col_q) ? JJT_W'(DAMP_BIAS) : '0;

	always_ff @(posedge i) begin
		if (s1_valid) begin
			jjt_row   <= row_q;
			jjt_col   <= col_q;
			jjt_entry <= prod_sum + bias;
		end
	end

endmodule

//--- source/jacobian_columns.sv
/*
 * jacobian columns
 * joint table and three-stage column pipe: offset, shared cross
 * products, then recombination into one 6-entry Jacobian column
 */
`timescale 1ns/1ps

module jacobian_columns import jacobian_pkg::*; #(
	parameter int N_JOINTS = 3
) (
	input  logic                         i,
	input  logic                         rst_n,
	input  logic                         joint_load,
	input  logic [IDX_W-1:0]             joint_index,
	input  logic                         joint_prismatic,
	input  logic signed [COORD_W-1:0]    axis_x,
	input  logic signed [COORD_W-1:0]    axis_y,
	input  logic signed [COORD_W-1:0]    axis_z,
	input  logic signed [COORD_W-1:0]    origin_x,
	input  logic signed [COORD_W-1:0]    origin_y,
	input  logic signed [COORD_W-1:0]    origin_z,
	input  logic                         start,
	input  logic signed [COORD_W-1:0]    end_x,
	input  logic signed [COORD_W-1:0]    end_y,
	input  logic signed [COORD_W-1:0]    end_z,
	input  logic                         col_issue,
	input  logic [IDX_W-1:0]             col_joint,
	input  logic [LANES-1:0][PROD_W-1:0] lane_prod,
	output logic [LANES-1:0][JAC_W-1:0]  col_lane_a,
	output logic [LANES-1:0][JAC_W-1:0]  col_lane_b,
	output logic                         jac_valid,
	output logic [IDX_W-1:0]             jac_joint,
	output logic [5:0][JAC_W-1:0]        jac_column
);

	localparam int OFF_W = COORD_W + 1;

	// joint table, index 0..2 is x, y, z
	logic signed [COORD_W-1:0] axis_tab   [MAX_JOINTS][3];
	logic signed [COORD_W-1:0] origin_tab [MAX_JOINTS][3];
	logic                      prism_tab  [MAX_JOINTS];
	logic signed [COORD_W-1:0] end_q      [3];

	logic                      s1_valid;
	logic signed [OFF_W-1:0]   off1_q  [3];
	logic signed [COORD_W-1:0] axis1_q [3];
	logic                      prism1_q;
	logic [IDX_W-1:0]          joint1_q;

	logic                      s2_valid;
	logic signed [COORD_W-1:0] axis2_q [3];
	logic                      prism2_q;
	logic [IDX_W-1:0]          joint2_q;
	logic signed [JAC_W-1:0]   lin [3];

	// rows beyond the configured arm are never read
	always_ff @(posedge i) begin
		if (joint_load && joint_index < IDX_W'(N_JOINTS)) begin
			axis_tab[joint_index][0]   <= axis_x;
			axis_tab[joint_index][1]   <= axis_y;
			axis_tab[joint_index][2]   <= axis_z;
			origin_tab[joint_index][0] <= origin_x;
			origin_tab[joint_index][1] <= origin_y;
			origin_tab[joint_index][2] <= origin_z;
			prism_tab[joint_index]     <= joint_prismatic;
		end
		if (start) begin
			end_q[0] <= end_x;
			end_q[1] <= end_y;
			end_q[2] <= end_z;
		end
	end

	always_ff @(posedge i) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			jac_valid <= 1'b0;
		end else begin
			s1_valid  <= col_issue;
			s2_valid  <= s1_valid;
			jac_valid <= s2_valid;
		end
	end

	// stage 1, offset from joint origin to end point
	always_ff @(posedge i) begin
		if (col_issue) begin
			for (int c = 0; c < 3; c++) begin
				off1_q[c]  <= OFF_W'(end_q[c]) - OFF_W'(origin_tab[col_joint][c]);
				axis1_q[c] <= axis_tab[col_joint][c];
			end
			prism1_q <= prism_tab[col_joint];
			joint1_q <= col_joint;
		end
	end

	// cross-product operand pairs, zero when not issuing
	always_comb begin
		col_lane_a = '0;
		col_lane_b = '0;
		if (s1_valid) begin
			col_lane_a[0] = JAC_W'(axis1_q[1]);
			col_lane_b[0] = JAC_W'(off1_q[2]);
			col_lane_a[1] = JAC_W'(axis1_q[2]);
			col_lane_b[1] = JAC_W'(off1_q[1]);
			col_lane_a[2] = JAC_W'(axis1_q[2]);
			col_lane_b[2] = JAC_W'(off1_q[0]);
			col_lane_a[3] = JAC_W'(axis1_q[0]);
			col_lane_b[3] = JAC_W'(off1_q[2]);
			col_lane_a[4] = JAC_W'(axis1_q[0]);
			col_lane_b[4] = JAC_W'(off1_q[1]);
			col_lane_a[5] = JAC_W'(axis1_q[1]);
			col_lane_b[5] = JAC_W'(off1_q[0]);
		end
	end

	// stage 2, wait for the lane products
	always_ff @(posedge i) begin
		if (s1_valid) begin
			axis2_q  <= axis1_q;
			prism2_q <= prism1_q;
			joint2_q <= joint1_q;
		end
	end

	// axis x offset, differences always fit JAC_W
	always_comb begin
		for (int c = 0; c < 3; c++) begin
			lin[c] = JAC_W'($signed(lane_prod[2*c]) - $signed(lane_prod[2*c+1]));
		end
	end

	// stage 3, linear part in entries 0..2, angular part in 3..5
	always_ff @(posedge i) begin
		if (s2_valid) begin
			jac_joint <= joint2_q;
			for (int c = 0; c < 3; c++) begin
				if (prism2_q) begin
					jac_column[c]   <= JAC_W'(axis2_q[c]);
					jac_column[c+3] <= '0;
				end else begin
					jac_column[c]   <= lin[c];
					jac_column[c+3] <= JAC_W'(axis2_q[c]);
				end
			end
		end
	end

endmodule

//--- source/lane_multiplier.sv
/*
 * lane multiplier
 * bank of registered signed multipliers shared by the cross products
 * of the column phase and the dot products of the J*J' phase
 */
`timescale 1ns/1ps

module lane_multiplier import jacobian_pkg::*; (
	input  logic                         i,
	input  logic [LANES-1:0][JAC_W-1:0]  lane_a,
	input  logic [LANES-1:0][JAC_W-1:0]  lane_b,
	output logic [LANES-1:0][PROD_W-1:0] lane_prod
);

	logic signed [PROD_W-1:0] prod [LANES];

	// full precision, operands sign-extended to the product width
	always_comb begin
		for (int j = 0; j < LANES; j++) begin
			prod[j] = PROD_W'($signed(lane_a[j])) * PROD_W'($signed(lane_b[j]));
		end
	end

	// one cycle of latency, idle lanes simply multiply zeros
	always_ff @(posedge i) begin
		for (int j = 0; j < LANES; j++) begin
			lane_prod[j] <= prod[j];
		end
	end

endmodule

//--- source/jacobian_sequencer.sv
/*
 * jacobian sequencer
 * steps through the column phase and the 36 entries of J*J', issuing one
 * strobe per cycle and pulsing done with the last entry
 */
`timescale 1ns/1ps

module jacobian_sequencer import jacobian_pkg::*; #(
	parameter int N_JOINTS = 3
) (
	input  logic             i,
	input  logic             rst_n,
	input  logic             start,
	output logic             busy,
	output logic             done,
	output logic             col_issue,
	output logic [IDX_W-1:0] col_joint,
	output logic             ent_issue,
	output logic [IDX_W-1:0] ent_row,
	output logic [IDX_W-1:0] ent_col
);

	localparam logic [IDX_W-1:0] LAST_JOINT = IDX_W'(N_JOINTS - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(5);
	// last column leaves the pipe three cycles after its issue
	localparam logic [1:0] DRAIN_LAST = 2'd2;
	// last entry still has two stages to go in jjt_bias
	localparam logic [1:0] FLUSH_LAST = 2'd1;

	jac_phase_t       phase;
	logic [IDX_W-1:0] joint_cnt;
	logic [IDX_W-1:0] row_cnt;
	logic [IDX_W-1:0] col_cnt;
	logic [1:0]       wait_cnt;

	always_ff @(posedge i) begin
		if (!rst_n) begin
			phase     <= PH_IDLE;
			busy      <= 1'b0;
			done      <= 1'b0;
			col_issue <= 1'b0;
			col_joint <= '0;
			ent_issue <= 1'b0;
			ent_row   <= '0;
			ent_col   <= '0;
			joint_cnt <= '0;
			row_cnt   <= '0;
			col_cnt   <= '0;
			wait_cnt  <= '0;
		end else begin
			// busy trails the phase by one cycle
			busy      <= (phase != PH_IDLE);
			col_issue <= 1'b0;
			ent_issue <= 1'b0;
			done      <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (start && !busy) begin
						phase     <= PH_COLUMNS;
						joint_cnt <= '0;
					end
				end
				PH_COLUMNS: begin
					col_issue <= 1'b1;
					col_joint <= joint_cnt;
					joint_cnt <= joint_cnt + 1'b1;
					if (joint_cnt == LAST_JOINT) begin
						phase    <= PH_DRAIN;
						wait_cnt <= '0;
					end
				end
				PH_DRAIN: begin
					// lanes stay free until the last column is stored
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == DRAIN_LAST) begin
						phase   <= PH_PRODUCT;
						row_cnt <= '0;
						col_cnt <= '0;
					end
				end
				PH_PRODUCT: begin
					ent_issue <= 1'b1;
					ent_row   <= row_cnt;
					ent_col   <= col_cnt;
					// row-major walk over the 6x6 result
					if (col_cnt == LAST_IDX) begin
						col_cnt <= '0;
						row_cnt <= row_cnt + 1'b1;
					end else begin
						col_cnt <= col_cnt + 1'b1;
					end
					if (row_cnt == LAST_IDX && col_cnt == LAST_IDX) begin
						phase    <= PH_FLUSH;
						wait_cnt <= '0;
					end
				end
				PH_FLUSH: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == FLUSH_LAST) begin
						done  <= 1'b1;
						phase <= PH_IDLE;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

//--- source/jacobian_pkg.sv
/*
 * jacobian package
 * datapath widths, damping constant and phase encoding shared by the
 * damped Jacobian engine
 */
package jacobian_pkg;

	// axis and position components, signed
	localparam int COORD_W = 12;

	// one Jacobian entry, wide enough for a cross-product difference
	localparam int JAC_W = 26;

	// one lane product
	localparam int PROD_W = 2 * JAC_W;

	// one J*J' entry, sum of up to six lane products plus bias
	localparam int JJT_W = 56;

	// shared multiplier lanes
	localparam int LANES = 6;

	// added to every diagonal entry of J*J'
	localparam int DAMP_BIAS = 64;

	// joint table depth, one lane per joint in the product phase
	localparam int MAX_JOINTS = LANES;

	// joint, row and column index width
	localparam int IDX_W = $clog2(MAX_JOINTS);

	// sequencer phases
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_COLUMNS,
		PH_DRAIN,
		PH_PRODUCT,
		PH_FLUSH
	} jac_phase_t;

endpackage
